//--- divsqrt_multi.f
source/divsqrt_pkg.sv
source/pipe_regs.sv
source/iter_divsqrt.sv
source/divsqrt_ctrl.sv
source/divsqrt_multi.sv
bench/tb_divsqrt_multi.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_divsqrt_multi \
  -f divsqrt_multi.f \
  -o tb_divsqrt_multi

sim_out=$(./obj_dir/tb_divsqrt_multi)
echo "$sim_out"
echo "$sim_out" | grep -q "TEST RESULT: PASS"

//--- bench/tb_divsqrt_multi.sv
// Testbench for default parameters only; expects at most 2000 cycles per drain and runs with assertions on

`default_nettype none
`timescale 1ns/1ps

module tb_divsqrt_multi import divsqrt_pkg::*; ;

  localparam time         CLK_PERIOD = 40ns;
  localparam time         DRIVE      = 2ns;
  localparam int unsigned WAIT_LIMIT = 500;
  localparam int unsigned DRAIN_MAX  = 2000;

  typedef struct packed {
    data_t result;
    logic  dz;
    tag_t  tag;
  } exp_t;

  logic  clk_i, rst_i, flush_i;
  logic  in_valid_i, in_ready_o, out_valid_o, out_ready_i;
  op_e   op_i;
  data_t operand_a_i, operand_b_i, result_o;
  tag_t  tag_i, tag_o;
  logic  dz_o, busy_o;

  // Scoreboard queue and the expected head for the output checks
  exp_t        exp_q[$];
  data_t       exp_result;
  logic        exp_dz;
  tag_t        exp_tag;
  logic        exp_pend;
  logic        quiet_chk;
  logic        bp_mode;
  logic        timed_out;
  tag_t        next_tag;
  int unsigned err_count, n_in, n_out;
  integer      seed;
  logic [31:0] rnd;
  data_t       divisor;

  divsqrt_multi u_divsqrt_multi (
    .clk_i, .rst_i, .flush_i, .in_valid_i, .in_ready_o, .op_i, .operand_a_i,
    .operand_b_i, .tag_i, .out_valid_o, .out_ready_i, .result_o, .dz_o, .tag_o, .busy_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  function automatic data_t floor_quotient(input data_t a, input data_t b);
    if (b == '0) return '1;
    return a / b;
  endfunction

  // Largest r with r*r not above a
  function automatic data_t floor_root(input data_t a);
    int unsigned r;
    r = 0;
    while ((r + 1) * (r + 1) <= 32'(a)) r++;
    return data_t'(r);
  endfunction

  // Transfers are decided at the falling edge, before the rising edge that takes them
  always @(negedge clk_i) begin : monitor
    exp_t e;
    if (rst_i || flush_i) begin
      exp_q.delete();
      exp_pend = 1'b0;
    end else begin
      if (out_valid_o && out_ready_i) begin
        exp_pend = (exp_q.size() != 0);
        if (exp_pend) begin
          e = exp_q.pop_front();
          exp_result = e.result;
          exp_dz     = e.dz;
          exp_tag    = e.tag;
          n_out++;
        end else begin
          err_count++;
          $display("Result delivered with no operation pending");
        end
      end
      if (in_valid_i && in_ready_o) begin
        e.tag    = tag_i;
        e.dz     = (op_i == OP_DIV) && (operand_b_i == '0);
        e.result = (op_i == OP_SQRT) ? floor_root(operand_a_i)
                                     : floor_quotient(operand_a_i, operand_b_i);
        exp_q.push_back(e);
        n_in++;
      end
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
    out_valid_o && out_ready_i && exp_pend |-> result_o == exp_result)
    else begin
      err_count++;
      $display("Error: result_o = %h, expected %h", $sampled(result_o), exp_result);
    end

  assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
    out_valid_o && out_ready_i && exp_pend |-> dz_o == exp_dz)
    else begin
      err_count++;
      $display("Error: dz_o = %h, expected %h", $sampled(dz_o), exp_dz);
    end

  assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
    out_valid_o && out_ready_i && exp_pend |-> tag_o == exp_tag)
    else begin
      err_count++;
      $display("Error: tag_o = %h, expected %h", $sampled(tag_o), exp_tag);
    end

  // Stalled output must keep its payload
  assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
    out_valid_o && !out_ready_i |=>
      out_valid_o && $stable(result_o) && $stable(dz_o) && $stable(tag_o))
    else begin
      err_count++;
      $display("Output dropped or changed while out_ready_i was low");
    end

  // Nothing in flight after a flush
  assert property (@(posedge clk_i) disable iff (rst_i) quiet_chk |-> !out_valid_o)
    else begin
      err_count++;
      $display("Error: out_valid_o = %h after flush, expected 0", $sampled(out_valid_o));
    end

  assert property (@(posedge clk_i) disable iff (rst_i) quiet_chk |-> !busy_o)
    else begin
      err_count++;
      $display("Error: busy_o = %h after flush, expected 0", $sampled(busy_o));
    end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------

  // Random stall pattern downstream in back-pressure mode
  initial begin
    logic [31:0] stall_rnd;
    forever begin
      @(posedge clk_i);
      // Drawn at the edge itself, apart from the operand draws
      stall_rnd = bp_mode ? $random(seed) : 32'd1;
      #DRIVE;
      out_ready_i = stall_rnd[0];
    end
  end

  task automatic send_op(input op_e op, input data_t a, input data_t b);
    int unsigned waited;
    logic        fire;
    if (timed_out) return;
    waited      = 0;
    fire        = 1'b0;
    in_valid_i  = 1'b1;
    op_i        = op;
    operand_a_i = a;
    operand_b_i = b;
    tag_i       = next_tag;
    while (!fire && !timed_out) begin
      @(negedge clk_i);
      fire = in_ready_o;
      @(posedge clk_i);
      #DRIVE;
      waited++;
      if (!fire && waited > WAIT_LIMIT) begin
        timed_out = 1'b1;
        err_count++;
        $display("Timeout: the DUT never accepted an operation");
      end
    end
    in_valid_i = 1'b0;
    next_tag++;
  endtask

  task automatic drain_results();
    int unsigned waited;
    waited = 0;
    while (exp_q.size() != 0 && !timed_out) begin
      @(posedge clk_i);
      #DRIVE;
      waited++;
      if (waited > DRAIN_MAX) begin
        timed_out = 1'b1;
        err_count++;
        $display("Timeout: %0d results never came out", exp_q.size());
      end
    end
    // Let the last output check run
    repeat (2) @(posedge clk_i);
    #DRIVE;
  endtask

  initial begin
    seed = 32'h8390_f009;
    {rst_i, flush_i, in_valid_i, operand_a_i, operand_b_i, tag_i} = '0;
    op_i        = OP_DIV;
    out_ready_i = 1'b1;
    {exp_pend, quiet_chk, bp_mode, timed_out} = '0;
    {exp_result, exp_dz, exp_tag, next_tag}   = '0;
    {err_count, n_in, n_out} = '0;

    rst_i = 1'b1;
    repeat (10) @(posedge clk_i);
    #DRIVE;
    rst_i = 1'b0;

    // Idle state right after reset
    @(negedge clk_i);
    assert (!out_valid_o) else begin
      err_count++;
      $display("Error: out_valid_o = %h after reset, expected 0", out_valid_o);
    end
    assert (!busy_o) else begin
      err_count++;
      $display("Error: busy_o = %h after reset, expected 0", busy_o);
    end
    assert (in_ready_o) else begin
      err_count++;
      $display("Error: in_ready_o = %h after reset, expected 1", in_ready_o);
    end
    @(posedge clk_i);
    #DRIVE;

    // Divides with nonzero divisors
    for (int i = 0; i < 30; i++) begin
      rnd = $random(seed);
      // Narrow divisors reach the upper quotient bits
      divisor = rnd[15:0] >> i[3:0];
      send_op(OP_DIV, rnd[31:16], (divisor == '0) ? 16'h0001 : divisor);
    end
    // Zero divisors
    send_op(OP_DIV, 16'h1234, 16'h0000);
    send_op(OP_DIV, 16'h0000, 16'h0000);
    send_op(OP_DIV, 16'hffff, 16'h0000);
    // Square roots with the extremes
    send_op(OP_SQRT, 16'h0000, 16'h0000);
    send_op(OP_SQRT, 16'hffff, 16'h0000);
    for (int i = 0; i < 20; i++) begin
      rnd = $random(seed);
      send_op(OP_SQRT, rnd[15:0], rnd[31:16]);
    end
    drain_results();

    // Mixed work under random back-pressure
    bp_mode = 1'b1;
    for (int i = 0; i < 40; i++) begin
      rnd = $random(seed);
      send_op(rnd[0] ? OP_SQRT : OP_DIV, rnd[31:16], {rnd[15:4], 4'h0});
    end
    drain_results();
    bp_mode = 1'b0;

    // Flush in the middle of a divide
    send_op(OP_DIV, 16'hbeef, 16'h0007);
    repeat (5) @(posedge clk_i);
    #DRIVE;
    flush_i = 1'b1;
    @(posedge clk_i);
    #DRIVE;
    flush_i   = 1'b0;
    quiet_chk = 1'b1;
    repeat (20) @(posedge clk_i);
    #DRIVE;
    quiet_chk = 1'b0;
    send_op(OP_SQRT, 16'h9c40, 16'h0000);
    drain_results();

    $display("Operations %0d, results %0d, errors %0d", n_in, n_out, err_count);
    if (err_count == 0 && !timed_out) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/divsqrt_multi.sv
// Top level; busy_o sees only the last stage of each pipe, so deep pipes can hide items from it

`default_nettype none
`timescale 1ns/1ps

module divsqrt_multi import divsqrt_pkg::*; #(
  parameter int unsigned NumInpRegs = 1,
  parameter int unsigned NumOutRegs = 1
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  flush_i,
  // Input handshake and payload
  input  logic  in_valid_i,
  output logic  in_ready_o,
  input  op_e   op_i,
  input  data_t operand_a_i,
  input  data_t operand_b_i,
  input  tag_t  tag_i,
  // Output handshake and payload
  output logic  out_valid_o,
  input  logic  out_ready_i,
  output data_t result_o,
  output logic  dz_o,
  output tag_t  tag_o,
  // Data in flight
  output logic  busy_o
);

  // Packed payload widths
  localparam int unsigned InpW = 1 + 2 * DATA_WIDTH + TAG_WIDTH;
  localparam int unsigned OutW = DATA_WIDTH + 1 + TAG_WIDTH;

  // ------------------------------------------------------------
  // Input pipeline
  // ------------------------------------------------------------

  logic [InpW-1:0] inp_data;
  logic            inp_valid;
  logic            inp_ready;
  op_e             inp_op;
  data_t           inp_a;
  data_t           inp_b;
  tag_t            inp_tag;

  pipe_regs #(
    .NumRegs      (NumInpRegs),
    .PayloadWidth (InpW)
  ) u_inp_pipe (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  ({op_i, operand_a_i, operand_b_i, tag_i}),
    .valid_o (inp_valid),
    .ready_i (inp_ready),
    .data_o  (inp_data)
  );

  // Unpack in the same order as packed above
  assign inp_op  = op_e'(inp_data[InpW-1]);
  assign {inp_a, inp_b, inp_tag} = inp_data[InpW-2:0];

  // ------------------------------------------------------------
  // Control and core
  // ------------------------------------------------------------

  logic  ctrl_valid;
  logic  ctrl_ready;
  data_t ctrl_result;
  logic  ctrl_dz;
  tag_t  ctrl_tag;
  logic  ctrl_busy;

  divsqrt_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .in_valid_i  (inp_valid),
    .in_ready_o  (inp_ready),
    .op_i        (inp_op),
    .operand_a_i (inp_a),
    .operand_b_i (inp_b),
    .tag_i       (inp_tag),
    .out_valid_o (ctrl_valid),
    .out_ready_i (ctrl_ready),
    .result_o    (ctrl_result),
    .dz_o        (ctrl_dz),
    .tag_o       (ctrl_tag),
    .busy_o      (ctrl_busy)
  );

  // ------------------------------------------------------------
  // Output pipeline
  // ------------------------------------------------------------

  logic [OutW-1:0] out_data;

  pipe_regs #(
    .NumRegs      (NumOutRegs),
    .PayloadWidth (OutW)
  ) u_out_pipe (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .valid_i (ctrl_valid),
    .ready_o (ctrl_ready),
    .data_i  ({ctrl_result, ctrl_dz, ctrl_tag}),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  (out_data)
  );

  assign {result_o, dz_o, tag_o} = out_data;

  // Anything visible in the pipes or the control counts as in flight
  assign busy_o = ctrl_busy | inp_valid | out_valid_o;

endmodule

`default_nettype wire

//--- source/divsqrt_ctrl.sv
// Control around the core; in_ready_o rises only in a start cycle, flush beats every other action

`default_nettype none
`timescale 1ns/1ps

module divsqrt_ctrl import divsqrt_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  flush_i,
  // From the input pipe
  input  logic  in_valid_i,
  output logic  in_ready_o,
  input  op_e   op_i,
  input  data_t operand_a_i,
  input  data_t operand_b_i,
  input  tag_t  tag_i,
  // To the output pipe
  output logic  out_valid_o,
  input  logic  out_ready_i,
  output data_t result_o,
  output logic  dz_o,
  output tag_t  tag_o,
  output logic  busy_o
);

  // ------------------------------------------------------------
  // Core interface
  // ------------------------------------------------------------

  logic  div_start;
  logic  sqrt_start;
  logic  unit_ready;
  logic  unit_done;
  data_t unit_result;
  logic  unit_dz;

  ctrl_state_e state_q, state_d;
  logic        can_accept;
  logic        accept;
  logic        out_valid;
  logic        busy;

  // Start pulses only for accepted work
  assign div_start  = accept & (op_i == OP_DIV);
  assign sqrt_start = accept & (op_i == OP_SQRT);
  assign in_ready_o = accept;

  iter_divsqrt u_core (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .div_start_i  (div_start),
    .sqrt_start_i (sqrt_start),
    .kill_i       (flush_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .ready_o      (unit_ready),
    .done_o       (unit_done),
    .result_o     (unit_result),
    .dz_o         (unit_dz)
  );

  // ------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------

  always_comb begin
    can_accept = 1'b0;
    out_valid  = 1'b0;
    busy       = 1'b0;
    state_d    = state_q;

    unique case (state_q)
      ST_IDLE: begin
        can_accept = 1'b1;
      end
      ST_BUSY: begin
        busy = 1'b1;
        if (unit_done) begin
          out_valid = 1'b1;
          if (out_ready_i) begin
            // Result leaves now, new work may start in the same cycle
            state_d    = ST_IDLE;
            can_accept = 1'b1;
          end else begin
            state_d = ST_HOLD;
          end
        end
      end
      ST_HOLD: begin
        busy      = 1'b1;
        out_valid = 1'b1;
        if (out_ready_i) begin
          state_d    = ST_IDLE;
          can_accept = 1'b1;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase

    accept = can_accept & in_valid_i & unit_ready & ~flush_i;
    if (accept) begin
      state_d = ST_BUSY;
    end

    // Flush cancels whatever is in flight
    if (flush_i) begin
      out_valid = 1'b0;
      busy      = 1'b0;
      state_d   = ST_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------------------------------------
  // Tag and hold registers
  // ------------------------------------------------------------

  tag_t  tag_q;
  data_t held_result_q;
  logic  held_dz_q;
  logic  hold_en;

  // Tag follows the operation from its start
  always_ff @(posedge clk_i) begin
    if (accept) begin
      tag_q <= tag_i;
    end
  end

  // Keep the result when downstream stalls in the done cycle
  assign hold_en = unit_done & ~out_ready_i;

  always_ff @(posedge clk_i) begin
    if (hold_en) begin
      held_result_q <= unit_result;
      held_dz_q     <= unit_dz;
    end
  end

  // Held copy wins while waiting
  assign result_o    = (state_q == ST_HOLD) ? held_result_q : unit_result;
  assign dz_o        = (state_q == ST_HOLD) ? held_dz_q : unit_dz;
  assign tag_o       = tag_q;
  assign out_valid_o = out_valid;
  assign busy_o      = busy;

endmodule

`default_nettype wire

//--- source/iter_divsqrt.sv
// Unsigned iterative core; result and dz_o hold meaning only while done_o is high

`default_nettype none
`timescale 1ns/1ps

module iter_divsqrt import divsqrt_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  // Start pulses, taken only while ready_o is high
  input  logic  div_start_i,
  input  logic  sqrt_start_i,
  input  logic  kill_i,
  input  data_t operand_a_i,
  input  data_t operand_b_i,
  // Status and result
  output logic  ready_o,
  output logic  done_o,
  output data_t result_o,
  output logic  dz_o
);

  // ------------------------------------------------------------
  // Local types and constants
  // ------------------------------------------------------------

  // Two spare bits cover the square root trial term
  localparam int unsigned RemW = DATA_WIDTH + 2;
  localparam int unsigned CntW = $clog2(DATA_WIDTH + 1);

  typedef logic [RemW-1:0] rem_t;
  typedef logic [CntW-1:0] cnt_t;

  // One quotient bit per step, or one root bit per step
  localparam cnt_t DivIters  = cnt_t'(DATA_WIDTH);
  localparam cnt_t SqrtIters = cnt_t'(DATA_WIDTH / 2);

  // ------------------------------------------------------------
  // State
  // ------------------------------------------------------------

  logic  busy_q;
  cnt_t  cnt_q;
  logic  sqrt_q;
  logic  dz_q;
  rem_t  rem_q;
  data_t sh_q;   // dividend or radicand, shifted out MSB first
  data_t res_q;  // quotient or root, shifted in LSB first
  data_t b_q;

  logic  start_ok;
  cnt_t  last_cnt;

  // Step inputs, muxed so the first step runs in the start cycle
  rem_t  rem_cur;
  data_t sh_cur;
  data_t res_cur;
  data_t b_cur;
  logic  sqrt_cur;

  // Step outputs
  rem_t  partial;
  rem_t  trial;
  logic  take;
  rem_t  rem_next;
  data_t sh_next;
  data_t res_next;

  assign last_cnt = sqrt_q ? SqrtIters : DivIters;
  assign done_o   = busy_q & (cnt_q == last_cnt);
  // Free again in the done cycle so back-to-back work is possible
  assign ready_o  = ~busy_q | done_o;
  assign start_ok = ready_o & (div_start_i | sqrt_start_i) & ~kill_i;

  // ------------------------------------------------------------
  // One iteration
  // ------------------------------------------------------------

  always_comb begin
    rem_cur  = start_ok ? '0 : rem_q;
    sh_cur   = start_ok ? operand_a_i : sh_q;
    res_cur  = start_ok ? '0 : res_q;
    b_cur    = start_ok ? operand_b_i : b_q;
    sqrt_cur = start_ok ? sqrt_start_i : sqrt_q;

    if (sqrt_cur) begin
      // Bring down two radicand bits, trial is 4*root + 1
      partial = {rem_cur[RemW-3:0], sh_cur[DATA_WIDTH-1:DATA_WIDTH-2]};
      trial   = {res_cur, 2'b01};
      sh_next = {sh_cur[DATA_WIDTH-3:0], 2'b00};
    end else begin
      // Restoring division, bring down one dividend bit
      partial = {rem_cur[RemW-2:0], sh_cur[DATA_WIDTH-1]};
      trial   = {2'b00, b_cur};
      sh_next = {sh_cur[DATA_WIDTH-2:0], 1'b0};
    end

    // Zero divisor always subtracts, so the quotient fills with ones
    take     = (partial >= trial);
    rem_next = take ? (partial - trial) : partial;
    res_next = {res_cur[DATA_WIDTH-2:0], take};
  end

  // ------------------------------------------------------------
  // Sequencing
  // ------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (kill_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_ok) begin
      busy_q <= 1'b1;
      cnt_q  <= cnt_t'(1);
    end else if (done_o) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (busy_q) begin
      cnt_q <= cnt_q + cnt_t'(1);
    end
  end

  // Datapath registers
  always_ff @(posedge clk_i) begin
    if (start_ok) begin
      sqrt_q <= sqrt_start_i;
      b_q    <= operand_b_i;
      dz_q   <= ~sqrt_start_i & (operand_b_i == '0);
    end
    // Steps stop at done so the result stays put for the done cycle
    if (start_ok || (busy_q && !done_o)) begin
      rem_q <= rem_next;
      sh_q  <= sh_next;
      res_q <= res_next;
    end
  end

  assign result_o = res_q;
  assign dz_o     = dz_q;

endmodule

`default_nettype wire

//--- source/pipe_regs.sv
// Elastic register chain; NumRegs of 0 gives plain wires, flush drops every stage's item

`default_nettype none
`timescale 1ns/1ps

module pipe_regs #(
  parameter int unsigned NumRegs      = 1,
  parameter int unsigned PayloadWidth = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    flush_i,
  // Upstream side
  input  logic                    valid_i,
  output logic                    ready_o,
  input  logic [PayloadWidth-1:0] data_i,
  // Downstream side
  output logic                    valid_o,
  input  logic                    ready_i,
  output logic [PayloadWidth-1:0] data_o
);

  if (NumRegs == 0) begin : gen_wires

    // No stages so the handshake passes straight through
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;

  end else begin : gen_regs

    // ------------------------------------------------------------
    // Stage signals
    // ------------------------------------------------------------

    // Index k is the state after k+1 register stages
    logic                    valid_q [NumRegs];
    logic [PayloadWidth-1:0] data_q  [NumRegs];
    // Stage k may take an item in this cycle
    logic                    ready   [NumRegs];

    // Ready enters from the far end and ripples back
    always_comb begin
      ready[NumRegs-1] = ready_i | ~valid_q[NumRegs-1];
      // Advance when the next stage moves on or only holds a bubble
      for (int k = int'(NumRegs) - 2; k >= 0; k--) begin
        ready[k] = ready[k+1] | ~valid_q[k];
      end
    end

    // ------------------------------------------------------------
    // Register stages
    // ------------------------------------------------------------

    for (genvar k = 0; k < NumRegs; k++) begin : gen_stage
      logic                    prev_valid;
      logic [PayloadWidth-1:0] prev_data;
      logic                    load;

      // First stage takes from upstream and the others from the stage before
      if (k == 0) begin : gen_entry
        assign prev_valid = valid_i;
        assign prev_data  = data_i;
      end else begin : gen_link
        assign prev_valid = valid_q[k-1];
        assign prev_data  = data_q[k-1];
      end

      // Data only moves when a real item is handed over
      assign load = ready[k] & prev_valid;

      // Valid bit cleared by reset and by flush
      always_ff @(posedge clk_i) begin
        if (rst_i) begin
          valid_q[k] <= 1'b0;
        end else if (flush_i) begin
          valid_q[k] <= 1'b0;
        end else if (ready[k]) begin
          valid_q[k] <= prev_valid;
        end
      end

      // Payload register with enable only
      always_ff @(posedge clk_i) begin
        if (load) begin
          data_q[k] <= prev_data;
        end
      end
    end

    // ------------------------------------------------------------
    // Exit
    // ------------------------------------------------------------

    assign ready_o = ready[0];
    assign valid_o = valid_q[NumRegs-1];
    assign data_o  = data_q[NumRegs-1];

  end

endmodule

`default_nettype wire

//--- source/divsqrt_pkg.sv
// Shared widths and encodings; DATA_WIDTH must be even so the square root has whole result bits

`default_nettype none

package divsqrt_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------

  // Operand and result width, must stay even
  localparam int unsigned DATA_WIDTH = 16;
  // User tag returned with each result
  localparam int unsigned TAG_WIDTH = 4;

  // ------------------------------------------------------------
  // Vector types
  // ------------------------------------------------------------

  // Unsigned operand or result
  typedef logic [DATA_WIDTH-1:0] data_t;
  // Tag carried from input to output untouched
  typedef logic [TAG_WIDTH-1:0] tag_t;

  // ------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------

  // Operation select, one bit
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } op_e;

  // Control FSM states
  // Idle waits for work, busy runs the core, hold keeps an unaccepted result
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BUSY = 2'd1,
    ST_HOLD = 2'd2
  } ctrl_state_e;

endpackage

`default_nettype wire
